//--- common/probe_pkg.sv
/* widths, structs and fixed frame constants shared by the traffic probe
   byte 0 of every beat sits in data[7:0]; all stream fields are 256 bits wide */

package probe_pkg;

  ////////////////////////////////////////////////////////////
  // widths

  localparam int TDATA_W = 256;
  localparam int TSTRB_W = TDATA_W / 8;
  localparam int TUSER_W = 128;
  localparam int STAMP_W = 64;
  localparam int SEQ_W   = 32;

  // where the second beat of a test frame carries its fields
  localparam int SEQ_LSB   = 16;
  localparam int STAMP_LSB = SEQ_LSB + SEQ_W;

  ////////////////////////////////////////////////////////////
  // structs

  // one stream beat, 417 bits
  typedef struct packed {
    logic [TDATA_W-1:0] data;
    logic [TSTRB_W-1:0] strb;
    logic [TUSER_W-1:0] user;
    logic               last;
  } stream_beat_t;

  // generator settings, laid out like the old config words
  typedef struct packed {
    logic [TSTRB_W-1:0] last_strb;
    logic [31:0]        payload_words;
    logic [31:0]        frame_count;
    logic [31:0]        gap_cycles;
  } gen_cfg_t;

  // one statistics record, most significant field first
  typedef struct packed {
    logic [15:0]        port_id;
    logic [31:0]        tag;
    logic [STAMP_W-1:0] tx_stamp;
    logic [STAMP_W-1:0] rx_stamp;
    logic [SEQ_W-1:0]   seq_arrived;
    logic [SEQ_W-1:0]   seq_expected;
    logic [15:0]        marker;
  } stat_record_t;

  // result of the latest returning frame
  typedef struct packed {
    logic [STAMP_W-1:0] tx_stamp;
    logic [STAMP_W-1:0] rx_stamp;
    logic [SEQ_W-1:0]   seq_arrived;
    logic [SEQ_W-1:0]   seq_expected;
  } frame_result_t;

  // read-only statistics seen by software
  typedef struct packed {
    logic [STAMP_W-1:0] tx_stamp;
    logic [STAMP_W-1:0] rx_stamp;
    logic [SEQ_W-1:0]   seq_arrived;
    logic [SEQ_W-1:0]   seq_expected;
    logic [31:0]        dma_frame_count;
  } probe_stats_t;

  ////////////////////////////////////////////////////////////
  // header beats, eth + ip fields packed from the top byte down

  localparam logic [TDATA_W-1:0] TEST_HDR_DATA = {8'h00, 32'h00000700, 16'h0900,
    32'h00000600, 8'h01, 32'h0, 16'h0200, 16'h0888, 48'hbbbbbbbbbbbb, 48'haaaaaaaaaaaa};
  localparam logic [TUSER_W-1:0] TEST_HDR_USER = 128'h05_01_0040;

  localparam logic [TDATA_W-1:0] STAT_HDR_DATA = {8'h00, 32'h00000700, 16'h0900,
    32'h00000600, 8'h01, 32'h0, 16'h0200, 16'h0008, 48'hcccccccccccc, 48'hdddddddddddd};
  // port bits 0x02 steer statistics frames to the host
  localparam logic [TUSER_W-1:0] STAT_HDR_USER = 128'h02_80_0320;

  localparam logic [7:0]  PAD_BYTE      = 8'hC3;
  // tail of the ip destination address, spills into the first payload beat
  localparam logic [15:0] IP_TAIL       = 16'h0007;
  localparam logic [31:0] RECORD_TAG    = 32'hcafe_cafe;
  localparam logic [15:0] RECORD_MARKER = 16'hcafe;

endpackage

//--- hw/rx_frame_check.sv
`timescale 1ns/1ns
/* always ready, so every rx_valid cycle is a transfer
   rec_write pulses two cycles after a frame's second beat; one record per frame */

module rx_frame_check
  import probe_pkg::*;
#(
  parameter int unsigned PORT_ID = 20
) (
  input  logic               S_AXI_ACLK,
  input  logic               S_AXI_ARESETN,
  input  logic               clear,
  input  stream_beat_t       rx_beat,
  input  logic               rx_valid,
  input  logic [STAMP_W-1:0] stamp_counter,
  output stat_record_t       rec_data,
  output logic               rec_write,
  output frame_result_t      last_result
);

  typedef enum logic [1:0] {
    ST_WAIT,
    ST_HEADER,
    ST_SECOND
  } rx_state_t;

  rx_state_t        state;
  logic [SEQ_W-1:0] rx_count;
  logic             second_hit;
  logic             hit_q;

  // second beat of a frame arrives now
  assign second_hit = rx_valid && (state == ST_HEADER);

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      state       <= ST_WAIT;
      rx_count    <= '0;
      hit_q       <= 1'b0;
      rec_write   <= 1'b0;
      last_result <= '0;
    end else if (clear) begin
      state       <= ST_WAIT;
      rx_count    <= '0;
      hit_q       <= 1'b0;
      rec_write   <= 1'b0;
      last_result <= '0;
    end else begin
      // two-stage pulse toward the FIFO
      hit_q     <= second_hit;
      rec_write <= hit_q;
      case (state)
        ST_WAIT: begin
          // header beat, a lone one-beat frame is skipped
          if (rx_valid && !rx_beat.last) begin
            state <= ST_HEADER;
          end
        end
        ST_HEADER: begin
          if (rx_valid) begin
            state                    <= rx_beat.last ? ST_WAIT : ST_SECOND;
            last_result.seq_arrived  <= rx_beat.data[SEQ_LSB +: SEQ_W];
            last_result.tx_stamp     <= rx_beat.data[STAMP_LSB +: STAMP_W];
            last_result.rx_stamp     <= stamp_counter;
            last_result.seq_expected <= rx_count;
            rx_count                 <= rx_count + 1'b1;
          end
        end
        ST_SECOND: begin
          // rest of the payload, wait for the end
          if (rx_valid && rx_beat.last) begin
            state <= ST_WAIT;
          end
        end
        default: state <= ST_WAIT;
      endcase
    end
  end

  // record built straight from the latched result
  assign rec_data = '{
    port_id:      16'(PORT_ID),
    tag:          RECORD_TAG,
    tx_stamp:     last_result.tx_stamp,
    rx_stamp:     last_result.rx_stamp,
    seq_arrived:  last_result.seq_arrived,
    seq_expected: last_result.seq_expected,
    marker:       RECORD_MARKER
  };

endmodule

//--- hw/traffic_probe_top.sv
`timescale 1ns/1ns
/* the return stream has no back-pressure; records arriving at a full FIFO are lost
   keep DRAIN_THRESHOLD at or below FIFO_DEPTH */

module traffic_probe_top
  import probe_pkg::*;
#(
  parameter int unsigned PORT_ID         = 20,
  parameter int unsigned FIFO_DEPTH      = 32,
  parameter int unsigned DRAIN_THRESHOLD = 24,
  parameter int unsigned DRAIN_RECORDS   = 29
) (
  input  logic               S_AXI_ACLK,
  input  logic               S_AXI_ARESETN,
  input  logic               clear,
  input  logic               start,
  input  gen_cfg_t           cfg,
  input  logic [STAMP_W-1:0] stamp_counter,
  // test stream out
  output stream_beat_t       tx_beat,
  output logic               tx_valid,
  input  logic               tx_ready,
  // return stream in
  input  stream_beat_t       rx_beat,
  input  logic               rx_valid,
  // statistics stream out
  output stream_beat_t       dma_beat,
  output logic               dma_valid,
  input  logic               dma_ready,
  output probe_stats_t       stats
);

  stat_record_t  rec_data;
  logic          rec_write;
  frame_result_t last_result;
  stat_record_t  rd_data;
  logic          rd_en;
  logic          fifo_empty;
  logic          last_one;
  logic          above_threshold;
  logic [31:0]   dma_frame_count;

  tx_frame_gen u_tx_gen (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .clear         (clear),
    .start         (start),
    .cfg           (cfg),
    .stamp_counter (stamp_counter),
    .tx_beat       (tx_beat),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready)
  );

  rx_frame_check #(.PORT_ID(PORT_ID)) u_rx_check (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .clear         (clear),
    .rx_beat       (rx_beat),
    .rx_valid      (rx_valid),
    .stamp_counter (stamp_counter),
    .rec_data      (rec_data),
    .rec_write     (rec_write),
    .last_result   (last_result)
  );

  // full is only needed inside the FIFO to drop writes
  stats_fifo #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .DRAIN_THRESHOLD (DRAIN_THRESHOLD)
  ) u_stats_fifo (
    .S_AXI_ACLK      (S_AXI_ACLK),
    .S_AXI_ARESETN   (S_AXI_ARESETN),
    .clear           (clear),
    .wr_data         (rec_data),
    .wr_en           (rec_write),
    .rd_en           (rd_en),
    .rd_data         (rd_data),
    .empty           (fifo_empty),
    .last_one        (last_one),
    .full            (),
    .above_threshold (above_threshold)
  );

  stats_drain #(.DRAIN_RECORDS(DRAIN_RECORDS)) u_stats_drain (
    .S_AXI_ACLK      (S_AXI_ACLK),
    .S_AXI_ARESETN   (S_AXI_ARESETN),
    .clear           (clear),
    .rd_data         (rd_data),
    .empty           (fifo_empty),
    .last_one        (last_one),
    .above_threshold (above_threshold),
    .rd_en           (rd_en),
    .dma_beat        (dma_beat),
    .dma_valid       (dma_valid),
    .dma_ready       (dma_ready),
    .dma_frame_count (dma_frame_count)
  );

  // read-only view for software
  assign stats = '{
    tx_stamp:        last_result.tx_stamp,
    rx_stamp:        last_result.rx_stamp,
    seq_arrived:     last_result.seq_arrived,
    seq_expected:    last_result.seq_expected,
    dma_frame_count: dma_frame_count
  };

endmodule

//--- hw/tx_frame_gen.sv
`timescale 1ns/1ns
/* cfg is taken once per burst when start is seen in idle; payload_words >= 1 assumed
   the departure stamp is the stamp_counter value at the header beat's transfer */

module tx_frame_gen
  import probe_pkg::*;
(
  input  logic               S_AXI_ACLK,
  input  logic               S_AXI_ARESETN,
  input  logic               clear,
  input  logic               start,
  input  gen_cfg_t           cfg,
  input  logic [STAMP_W-1:0] stamp_counter,
  output stream_beat_t       tx_beat,
  output logic               tx_valid,
  input  logic               tx_ready
);

  // padding bytes ahead of stamp, sequence number and ip tail
  localparam int PAD_BYTES = (TDATA_W - STAMP_W - SEQ_W - 16) / 8;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_GAP,
    ST_HEADER,
    ST_PAYLOAD
  } tx_state_t;

  tx_state_t          state;
  gen_cfg_t           cfg_q;
  logic [31:0]        gap_cnt;
  logic [31:0]        frames_left;
  logic [31:0]        words_left;
  logic [SEQ_W-1:0]   seq_num;
  logic [STAMP_W-1:0] depart_stamp;
  logic               tx_fire;
  logic               first_word;
  logic               last_word;

  assign tx_fire    = tx_valid && tx_ready;
  // words_left still at its load value on the first payload beat
  assign first_word = (words_left == cfg_q.payload_words);
  assign last_word  = (words_left <= 32'd1);

  ////////////////////////////////////////////////////////////
  // burst FSM and counters

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      state       <= ST_IDLE;
      gap_cnt     <= '0;
      frames_left <= '0;
      words_left  <= '0;
      seq_num     <= '0;
    end else if (clear) begin
      state       <= ST_IDLE;
      gap_cnt     <= '0;
      frames_left <= '0;
      words_left  <= '0;
      seq_num     <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // a zero frame count leaves the generator idle
          if (start && (cfg.frame_count != 32'd0)) begin
            state       <= ST_GAP;
            frames_left <= cfg.frame_count;
            gap_cnt     <= cfg.gap_cycles;
          end
        end
        ST_GAP: begin
          gap_cnt <= gap_cnt - 32'd1;
          if (gap_cnt <= 32'd1) begin
            state <= ST_HEADER;
          end
        end
        ST_HEADER: begin
          if (tx_fire) begin
            state      <= ST_PAYLOAD;
            words_left <= cfg_q.payload_words;
          end
        end
        ST_PAYLOAD: begin
          if (tx_fire) begin
            words_left <= words_left - 32'd1;
            if (last_word) begin
              // frame done, sequence number runs on across bursts
              seq_num     <= seq_num + 1'b1;
              frames_left <= frames_left - 32'd1;
              gap_cnt     <= cfg_q.gap_cycles;
              state       <= (frames_left == 32'd1) ? ST_IDLE : ST_GAP;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // burst settings and departure stamp
  always_ff @(posedge S_AXI_ACLK) begin
    if ((state == ST_IDLE) && start) begin
      cfg_q <= cfg;
    end
    // held so the first payload beat stays steady under back-pressure
    if ((state == ST_HEADER) && tx_fire) begin
      depart_stamp <= stamp_counter;
    end
  end

  ////////////////////////////////////////////////////////////
  // beat contents, decoded from state only

  always_comb begin
    tx_beat  = '0;
    tx_valid = 1'b0;
    case (state)
      ST_HEADER: begin
        tx_valid     = 1'b1;
        tx_beat.data = TEST_HDR_DATA;
        tx_beat.user = TEST_HDR_USER;
        tx_beat.strb = '1;
      end
      ST_PAYLOAD: begin
        tx_valid = 1'b1;
        if (first_word) begin
          tx_beat.data = {{PAD_BYTES{PAD_BYTE}}, depart_stamp, seq_num, IP_TAIL};
        end else begin
          tx_beat.data = {TSTRB_W{PAD_BYTE}};
        end
        // partial strobe only on the closing beat
        tx_beat.strb = last_word ? cfg_q.last_strb : '1;
        tx_beat.last = last_word;
      end
      default: ;
    endcase
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the traffic probe testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module traffic_probe_tb \
  -f traffic_probe.f -o traffic_probe_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/traffic_probe_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- sim/traffic_probe_props.sv
`timescale 1ns/1ns
/* stream rules on the traffic probe outputs, bound into traffic_probe_top
   the hold rules are off during reset and clear */

module traffic_probe_props
  import probe_pkg::*;
(
  input logic         S_AXI_ACLK,
  input logic         S_AXI_ARESETN,
  input logic         clear,
  input stream_beat_t tx_beat,
  input logic         tx_valid,
  input logic         tx_ready,
  input stream_beat_t dma_beat,
  input logic         dma_valid,
  input logic         dma_ready,
  input logic         rec_write
);

  // a stalled test beat holds until it is taken
  tx_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN || clear)
    (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_beat)))
    else $error("test stream beat or valid changed while stalled");

  // same rule on the statistics stream
  dma_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN || clear)
    (dma_valid && !dma_ready) |=> (dma_valid && $stable(dma_beat)))
    else $error("statistics stream beat or valid changed while stalled");

  // one record write per frame, never two cycles back to back
  rec_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    rec_write |=> !rec_write)
    else $error("record write stayed high for two cycles");

endmodule

bind traffic_probe_top traffic_probe_props u_props (
  .S_AXI_ACLK    (S_AXI_ACLK),
  .S_AXI_ARESETN (S_AXI_ARESETN),
  .clear         (clear),
  .tx_beat       (tx_beat),
  .tx_valid      (tx_valid),
  .tx_ready      (tx_ready),
  .dma_beat      (dma_beat),
  .dma_valid     (dma_valid),
  .dma_ready     (dma_ready),
  .rec_write     (rec_write)
);

//--- sim/traffic_probe_tb.sv
`timescale 1ns/1ns
/* random loopback test of traffic_probe_top, seed 63882, stamp_counter is the cycle count
   each pair of bursts around the clear adds up to DRAIN_THRESHOLD frames,
   so every drain starts after its last record is already in the FIFO */

module traffic_probe_tb
  import probe_pkg::*;
();

  localparam int unsigned PORT_ID         = 20;
  localparam int unsigned FIFO_DEPTH      = 32;
  localparam int unsigned DRAIN_THRESHOLD = 24;
  localparam int unsigned DRAIN_RECORDS   = 29;

  localparam int BURSTS       = 4;
  localparam int MIN_FRAMES   = 8;
  localparam int MAX_FRAMES   = DRAIN_THRESHOLD - MIN_FRAMES;
  localparam int MAX_WORDS    = 4;
  localparam int MAX_GAP      = 5;
  localparam int QUIET_CYCLES = 8;
  // longest burst plus its drain and quiet time, four times over for back-pressure
  localparam int BURST_CYCLES = MAX_FRAMES * (MAX_WORDS + 1 + MAX_GAP);
  localparam int CYCLE_LIMIT  =
    4 * BURSTS * (BURST_CYCLES + DRAIN_THRESHOLD + 1 + QUIET_CYCLES) + 20;

  logic               S_AXI_ACLK = 1'b0;
  logic               S_AXI_ARESETN;
  logic               clear;
  logic               start;
  gen_cfg_t           cfg;
  logic [STAMP_W-1:0] cycle      = '0;
  stream_beat_t       tx_beat;
  logic               tx_valid;
  logic               tx_ready   = 1'b0;
  stream_beat_t       rx_beat    = '0;
  logic               rx_valid   = 1'b0;
  stream_beat_t       dma_beat;
  logic               dma_valid;
  logic               dma_ready  = 1'b0;
  probe_stats_t       stats;

  // scoreboard state
  int           errors       = 0;
  int           checks       = 0;
  int           tx_total     = 0;
  int           stat_frames  = 0;
  int           records_seen = 0;
  gen_cfg_t     cur_cfg;
  int           tx_idx;
  logic [31:0]  tx_seq;
  int           rx_idx;
  logic [31:0]  rx_count;
  int           dma_idx;
  stat_record_t model_q[$];
  probe_stats_t model_stats;

  traffic_probe_top #(
    .PORT_ID         (PORT_ID),
    .FIFO_DEPTH      (FIFO_DEPTH),
    .DRAIN_THRESHOLD (DRAIN_THRESHOLD),
    .DRAIN_RECORDS   (DRAIN_RECORDS)
  ) DUT (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .clear         (clear),
    .start         (start),
    .cfg           (cfg),
    .stamp_counter (cycle),
    .tx_beat       (tx_beat),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .rx_beat       (rx_beat),
    .rx_valid      (rx_valid),
    .dma_beat      (dma_beat),
    .dma_valid     (dma_valid),
    .dma_ready     (dma_ready),
    .stats         (stats)
  );

  ////////////////////////////////////////////////////////////
  // clock, cycle count, ready and loopback

  always #20 S_AXI_ACLK = ~S_AXI_ACLK;

  always @(posedge S_AXI_ACLK) begin
    cycle <= cycle + 1'b1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the run did not complete", CYCLE_LIMIT);
      report_counts();
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ready high about 70% of the time on both output streams
  always @(posedge S_AXI_ACLK) begin
    tx_ready  <= ($urandom % 10) < 7;
    dma_ready <= ($urandom % 10) < 7;
  end

  // each transferred test beat comes back one cycle later
  always @(posedge S_AXI_ACLK) begin
    rx_valid <= tx_valid && tx_ready;
    rx_beat  <= tx_beat;
  end

  ////////////////////////////////////////////////////////////
  // check helpers

  task automatic compare_value(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERROR %s got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic confirm(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("check failed at cycle %0d, %s", cycle, what);
    end
  endtask

  task automatic report_counts();
    $display("checks %0d, errors %0d, test frames %0d, statistics frames %0d, records %0d",
             checks, errors, tx_total, stat_frames, records_seen);
  endtask

  ////////////////////////////////////////////////////////////
  // monitor and model, sampled on the rising edge

  always @(posedge S_AXI_ACLK) begin
    stat_record_t rec;
    stat_record_t exp_rec;
    logic         last_exp;
    if (!S_AXI_ARESETN || clear) begin
      tx_idx      = 0;
      tx_seq      = '0;
      rx_idx      = 0;
      rx_count    = '0;
      dma_idx     = 0;
      model_stats = '0;
      model_q.delete();
    end else begin
      compare_value("stats", stats, model_stats);
      // test stream, header then payload_words beats
      if (tx_valid && tx_ready) begin
        last_exp = (tx_idx != 0) && (tx_idx == cur_cfg.payload_words);
        if (tx_idx == 0) begin
          compare_value("tx_beat.data", tx_beat.data, TEST_HDR_DATA);
          compare_value("tx_beat.user", tx_beat.user, TEST_HDR_USER);
        end else if (tx_idx == 1) begin
          compare_value("tx_beat.data[255:112]", tx_beat.data[255:112], {18{PAD_BYTE}});
          compare_value("tx_beat.data[47:16]", tx_beat.data[47:16], tx_seq);
          compare_value("tx_beat.data[15:0]", tx_beat.data[15:0], IP_TAIL);
          confirm(tx_beat.data[111:48] < cycle, "departure stamp is not before the transfer");
        end else begin
          compare_value("tx_beat.data", tx_beat.data, {TSTRB_W{PAD_BYTE}});
        end
        compare_value("tx_beat.strb", tx_beat.strb,
                      last_exp ? cur_cfg.last_strb : {TSTRB_W{1'b1}});
        compare_value("tx_beat.last", tx_beat.last, last_exp);
        if (last_exp) begin
          tx_idx   = 0;
          tx_seq   = tx_seq + 1;
          tx_total++;
        end else begin
          tx_idx++;
        end
      end
      // returning frames, the second beat makes one expected record
      if (rx_valid) begin
        if (rx_idx == 1) begin
          rec.port_id      = 16'(PORT_ID);
          rec.tag          = RECORD_TAG;
          rec.tx_stamp     = rx_beat.data[111:48];
          rec.rx_stamp     = cycle;
          rec.seq_arrived  = rx_beat.data[47:16];
          rec.seq_expected = rx_count;
          rec.marker       = RECORD_MARKER;
          model_q.push_back(rec);
          rx_count                 = rx_count + 1;
          model_stats.tx_stamp     = rec.tx_stamp;
          model_stats.rx_stamp     = rec.rx_stamp;
          model_stats.seq_arrived  = rec.seq_arrived;
          model_stats.seq_expected = rec.seq_expected;
        end
        rx_idx = rx_beat.last ? 0 : rx_idx + 1;
      end
      // statistics stream
      if (dma_valid && dma_ready) begin
        if (dma_idx == 0) begin
          compare_value("dma_beat.data", dma_beat.data, STAT_HDR_DATA);
          compare_value("dma_beat.user", dma_beat.user, STAT_HDR_USER);
          compare_value("dma_beat.last", dma_beat.last, 1'b0);
          dma_idx = 1;
        end else begin
          rec = dma_beat.data;
          // first record has the ip tail over its marker
          if (dma_idx == 1) begin
            compare_value("dma_beat.data[15:0]", dma_beat.data[15:0], IP_TAIL);
            rec.marker = RECORD_MARKER;
          end
          compare_value("record port_id", rec.port_id, PORT_ID);
          compare_value("record tag", rec.tag, RECORD_TAG);
          compare_value("record marker", rec.marker, RECORD_MARKER);
          compare_value("record seq_arrived", rec.seq_arrived, rec.seq_expected);
          confirm(rec.rx_stamp > rec.tx_stamp, "record arrival stamp is not after departure");
          if (model_q.size() == 0) begin
            confirm(1'b0, "statistics record arrived with no frame left in the model");
          end else begin
            exp_rec = model_q.pop_front();
            compare_value("dma record", rec, exp_rec);
          end
          // frame closes at the record limit or when the model has nothing left
          compare_value("dma_beat.last", dma_beat.last,
                        (dma_idx == DRAIN_RECORDS) || (model_q.size() == 0));
          records_seen++;
          if (dma_beat.last) begin
            dma_idx = 0;
            stat_frames++;
            model_stats.dma_frame_count = model_stats.dma_frame_count + 1;
          end else begin
            dma_idx++;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus

  // all three streams idle for QUIET_CYCLES in a row
  task automatic wait_quiet();
    int idle;
    idle = 0;
    while (idle < QUIET_CYCLES) begin
      @(posedge S_AXI_ACLK);
      if (tx_valid || rx_valid || dma_valid) begin
        idle = 0;
      end else begin
        idle++;
      end
    end
  endtask

  task automatic run_burst(input int frames);
    gen_cfg_t c;
    int       base;
    c.gap_cycles    = 2 + $urandom % (MAX_GAP - 1);
    c.frame_count   = frames;
    c.payload_words = 1 + $urandom % MAX_WORDS;
    c.last_strb     = $urandom;
    base            = tx_total;
    cur_cfg         = c;
    cfg   <= c;
    start <= 1'b1;
    @(posedge S_AXI_ACLK);
    start <= 1'b0;
    while (tx_total - base < frames) begin
      @(posedge S_AXI_ACLK);
    end
    wait_quiet();
    compare_value("frames in burst", tx_total - base, frames);
  endtask

  task automatic apply_clear();
    clear <= 1'b1;
    @(posedge S_AXI_ACLK);
    clear <= 1'b0;
    @(posedge S_AXI_ACLK);
    confirm(!tx_valid && !dma_valid, "a valid output is still high after clear");
    compare_value("stats", stats, '0);
  endtask

  initial begin
    int n;
    int frames;
    void'($urandom(63882));
    S_AXI_ARESETN = 1'b0;
    clear         = 1'b0;
    start         = 1'b0;
    cfg           = '0;
    cur_cfg       = '0;
    frames        = 0;
    repeat (3) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
    @(posedge S_AXI_ACLK);
    for (n = 0; n < BURSTS; n++) begin
      // sequence numbers start again at 0 after this
      if (n == BURSTS / 2) begin
        apply_clear();
      end
      if (n % 2 == 0) begin
        frames = MIN_FRAMES + $urandom % (MAX_FRAMES - MIN_FRAMES + 1);
      end else begin
        frames = DRAIN_THRESHOLD - frames;
      end
      run_burst(frames);
    end
    compare_value("records left in model", model_q.size(), 0);
    compare_value("statistics frames", stat_frames, BURSTS / 2);
    report_counts();
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- stats/stats_drain.sv
`timescale 1ns/1ns
/* a drain starts once the FIFO passes its threshold and sends header plus records
   a frame closes after DRAIN_RECORDS records or on the record that empties the FIFO */

module stats_drain
  import probe_pkg::*;
#(
  parameter int unsigned DRAIN_RECORDS = 29
) (
  input  logic         S_AXI_ACLK,
  input  logic         S_AXI_ARESETN,
  input  logic         clear,
  input  stat_record_t rd_data,
  input  logic         empty,
  input  logic         last_one,
  input  logic         above_threshold,
  output logic         rd_en,
  output stream_beat_t dma_beat,
  output logic         dma_valid,
  input  logic         dma_ready,
  output logic [31:0]  dma_frame_count
);

  localparam int CNT_W = $clog2(DRAIN_RECORDS + 1);

  typedef enum logic [1:0] {
    ST_WAIT,
    ST_HEADER,
    ST_PAYLOAD
  } drain_state_t;

  drain_state_t     state;
  logic [CNT_W-1:0] rec_cnt;
  logic             dma_fire;
  logic             first_rec;
  logic             end_rec;

  assign dma_fire  = dma_valid && dma_ready;
  assign first_rec = (rec_cnt == '0);
  // record limit reached or FIFO about to run dry
  assign end_rec   = last_one || (rec_cnt == CNT_W'(DRAIN_RECORDS - 1));

  ////////////////////////////////////////////////////////////
  // drain FSM and frame counter

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      state           <= ST_WAIT;
      rec_cnt         <= '0;
      dma_frame_count <= '0;
    end else if (clear) begin
      state           <= ST_WAIT;
      rec_cnt         <= '0;
      dma_frame_count <= '0;
    end else begin
      case (state)
        ST_WAIT: begin
          if (above_threshold && !empty) begin
            state <= ST_HEADER;
          end
        end
        ST_HEADER: begin
          if (dma_fire) begin
            state   <= ST_PAYLOAD;
            rec_cnt <= '0;
          end
        end
        ST_PAYLOAD: begin
          if (dma_fire) begin
            rec_cnt <= rec_cnt + 1'b1;
            if (end_rec) begin
              state           <= ST_WAIT;
              dma_frame_count <= dma_frame_count + 32'd1;
            end
          end
        end
        default: state <= ST_WAIT;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // beat contents, head record shown until it is popped

  always_comb begin
    dma_beat  = '0;
    dma_valid = 1'b0;
    case (state)
      ST_HEADER: begin
        dma_valid     = 1'b1;
        dma_beat.data = STAT_HDR_DATA;
        dma_beat.user = STAT_HDR_USER;
        dma_beat.strb = '1;
      end
      ST_PAYLOAD: begin
        dma_valid     = 1'b1;
        dma_beat.data = rd_data;
        // first record carries the ip address tail in its low bytes
        if (first_rec) begin
          dma_beat.data[15:0] = IP_TAIL;
        end
        dma_beat.strb = '1;
        dma_beat.last = end_rec;
      end
      default: ;
    endcase
  end

  // pop exactly on a payload transfer
  assign rd_en = (state == ST_PAYLOAD) && dma_ready;

endmodule

//--- stats/stats_fifo.sv
`timescale 1ns/1ns
/* first-word fall-through: rd_data always shows the head entry
   writes into a full FIFO are lost, reads of an empty one are ignored */

module stats_fifo
  import probe_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH      = 32,
  parameter int unsigned DRAIN_THRESHOLD = 24
) (
  input  logic         S_AXI_ACLK,
  input  logic         S_AXI_ARESETN,
  input  logic         clear,
  input  stat_record_t wr_data,
  input  logic         wr_en,
  input  logic         rd_en,
  output stat_record_t rd_data,
  output logic         empty,
  output logic         last_one,
  output logic         full,
  output logic         above_threshold
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  stat_record_t     mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_ok;
  logic             rd_ok;

  // wrap at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= next_ptr(wr_ptr);
      if (rd_ok) rd_ptr <= next_ptr(rd_ptr);
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_ok) mem[wr_ptr] <= wr_data;
  end

  assign rd_data         = mem[rd_ptr];
  assign empty           = (count == '0);
  assign last_one        = (count == CNT_W'(1));
  assign full            = (count == CNT_W'(FIFO_DEPTH));
  assign above_threshold = (count >= CNT_W'(DRAIN_THRESHOLD));

endmodule

//--- traffic_probe.f
common/probe_pkg.sv
hw/tx_frame_gen.sv
hw/rx_frame_check.sv
stats/stats_fifo.sv
stats/stats_drain.sv
hw/traffic_probe_top.sv
sim/traffic_probe_props.sv
sim/traffic_probe_tb.sv
